// File: run.sh
#!/bin/sh
set -e

# run from the project root
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module core_tb -o core_tb_sim

./obj_dir/core_tb_sim > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
	echo "simulation reported errors"
	exit 1
fi
echo "simulation clean"

// File: source/alu_way.sv
`default_nettype none

module alu_way (
	input  logic                         clock,
	input  logic                         reset,
	input  superscalar_pkg::issue_pkt_t  issue,
	output superscalar_pkg::result_pkt_t result
);
	import superscalar_pkg::*;

	logic [XLEN-1:0] value;

	always_comb begin
		case (issue.alu_op)
			ALU_ADD: value = issue.opa + issue.opb;
			ALU_SUB: value = issue.opa - issue.opb;
			ALU_AND: value = issue.opa & issue.opb;
			ALU_OR:  value = issue.opa | issue.opb;
			ALU_XOR: value = issue.opa ^ issue.opb;
			default: value = '0;
		endcase
	end

	// result register feeds retire directly
	always_ff @(posedge clock) begin
		result.dest    <= issue.dest;
		result.value   <= value;
		result.halt    <= issue.halt;
		result.illegal <= issue.illegal;
		if (!reset)
			result.valid <= 1'b0;
		else
			result.valid <= issue.valid;
	end

endmodule

`default_nettype wire

// File: source/bundle_issue.sv
`default_nettype none

module bundle_issue (
	input  logic                                  clock,
	input  logic                                  reset,
	input  superscalar_pkg::fetch_bundle_t        fetch_bundle,
	output logic [superscalar_pkg::TAKEN_W-1:0]   taken,
	output logic [superscalar_pkg::REG_IDX_W-1:0] rd_idx  [2*superscalar_pkg::WAYS],
	input  logic [superscalar_pkg::XLEN-1:0]      rd_data [2*superscalar_pkg::WAYS],
	output superscalar_pkg::issue_pkt_t           issue   [superscalar_pkg::WAYS]
);
	import superscalar_pkg::*;

	inst_t            word     [WAYS];
	issue_pkt_t       dec      [WAYS];
	logic [WAYS-1:0]  uses_rs1;
	logic [WAYS-1:0]  uses_rs2;
	logic [WAYS-1:0]  hazard;
	logic [WAYS-1:0]  accept;
	logic [TAKEN_W-1:0] count;

	// true when a live source of w names a nonzero dest
	function automatic logic reads_dest(
		input logic                 use1,
		input logic                 use2,
		input inst_t                w,
		input logic [REG_IDX_W-1:0] dest
	);
		return (dest != '0) && ((use1 && w.r.rs1 == dest) || (use2 && w.r.rs2 == dest));
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// decode and operand read
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			word[w]          = fetch_bundle.inst[w];
			rd_idx[2*w]      = word[w].r.rs1;
			rd_idx[2*w + 1]  = word[w].r.rs2;   // unused by ADDI, read anyway
		end
	end

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			dec[w]        = '0;
			dec[w].alu_op = ALU_ADD;
			uses_rs1[w]   = 1'b0;
			uses_rs2[w]   = 1'b0;

			if (word[w] == INST_WFI) begin
				dec[w].halt = 1'b1;
			end else if (word[w].r.opcode == OPCODE_OP) begin
				uses_rs1[w] = 1'b1;
				uses_rs2[w] = 1'b1;
				dec[w].opb  = rd_data[2*w + 1];
				case ({word[w].r.funct7, word[w].r.funct3})
					{7'h00, 3'b000}: dec[w].alu_op = ALU_ADD;
					{7'h20, 3'b000}: dec[w].alu_op = ALU_SUB;
					{7'h00, 3'b111}: dec[w].alu_op = ALU_AND;
					{7'h00, 3'b110}: dec[w].alu_op = ALU_OR;
					{7'h00, 3'b100}: dec[w].alu_op = ALU_XOR;
					default:         dec[w].illegal = 1'b1;
				endcase
			end else if (word[w].i.opcode == OPCODE_OP_IMM && word[w].i.funct3 == 3'b000) begin
				uses_rs1[w] = 1'b1;   // ADDI
				dec[w].opb  = {{(XLEN-12){word[w].i.imm[11]}}, word[w].i.imm};
			end else begin
				dec[w].illegal = 1'b1;
			end

			if (dec[w].illegal) begin
				uses_rs1[w] = 1'b0;
				uses_rs2[w] = 1'b0;
			end

			dec[w].opa   = rd_data[2*w];
			dec[w].dest  = (dec[w].illegal || dec[w].halt) ? '0 : word[w].r.rd;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// hazard split
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int w = 0; w < WAYS; w++) begin
			hazard[w] = 1'b0;
			for (int j = 0; j < WAYS; j++) begin
				// older way in this bundle
				if (j < w && fetch_bundle.valid[j] &&
						reads_dest(uses_rs1[w], uses_rs2[w], word[w], dec[j].dest))
					hazard[w] = 1'b1;
				// result not yet computed, write-through can't cover it
				if (issue[j].valid &&
						reads_dest(uses_rs1[w], uses_rs2[w], word[w], issue[j].dest))
					hazard[w] = 1'b1;
			end
		end
	end

	// leading ways only, the first stopped way ends the run
	always_comb begin
		count = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (w == 0)
				accept[w] = fetch_bundle.valid[w] && !hazard[w];
			else
				accept[w] = accept[w-1] && fetch_bundle.valid[w] && !hazard[w];
			count = count + TAKEN_W'(accept[w]);
		end
		taken = reset ? count : '0;
	end

	////////////////////////////////////////////////////////////////////////////
	// issue registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int w = 0; w < WAYS; w++) begin
			issue[w] <= dec[w];
			if (!reset)
				issue[w].valid <= 1'b0;
			else
				issue[w].valid <= accept[w];   // rejected ways go in as bubbles
		end
	end

endmodule

`default_nettype wire

// File: source/reg_file.sv
`default_nettype none

module reg_file (
	input  logic                                  clock,
	input  logic                                  reset,
	input  superscalar_pkg::reg_write_t           writes  [superscalar_pkg::WAYS],
	input  logic [superscalar_pkg::REG_IDX_W-1:0] rd_idx  [2*superscalar_pkg::WAYS],
	output logic [superscalar_pkg::XLEN-1:0]      rd_data [2*superscalar_pkg::WAYS]
);
	import superscalar_pkg::*;

	logic [XLEN-1:0] regs [NUM_REGS];

	// later ways overwrite earlier ones, so the highest way wins
	always_ff @(posedge clock) begin
		if (!reset) begin
			for (int r = 0; r < NUM_REGS; r++)
				regs[r] <= '0;   // architectural state starts at zero
		end else begin
			for (int w = 0; w < WAYS; w++) begin
				if (writes[w].wr_en && writes[w].wr_idx != '0)
					regs[writes[w].wr_idx] <= writes[w].wr_data;
			end
		end
	end

	// read ports with write-through, same priority as the write side
	always_comb begin
		for (int p = 0; p < 2*WAYS; p++) begin
			rd_data[p] = regs[rd_idx[p]];
			for (int w = 0; w < WAYS; w++) begin
				if (writes[w].wr_en && writes[w].wr_idx == rd_idx[p])
					rd_data[p] = writes[w].wr_data;
			end
			if (rd_idx[p] == '0)
				rd_data[p] = '0;   // x0 is hardwired
		end
	end

endmodule

`default_nettype wire

// File: source/retire_unit.sv
`default_nettype none

module retire_unit (
	input  superscalar_pkg::result_pkt_t        result [superscalar_pkg::WAYS],
	output superscalar_pkg::reg_write_t         writes [superscalar_pkg::WAYS],
	output superscalar_pkg::commit_t            commit [superscalar_pkg::WAYS],
	output logic [superscalar_pkg::TAKEN_W-1:0] completed_insts,
	output superscalar_pkg::error_status_t      error_status
);
	import superscalar_pkg::*;

	logic any_illegal;
	logic any_halt;

	always_comb begin
		completed_insts = '0;
		any_illegal     = 1'b0;
		any_halt        = 1'b0;

		for (int w = 0; w < WAYS; w++) begin
			commit[w].valid   = result[w].valid;
			commit[w].wr_en   = result[w].valid && !result[w].illegal &&
				!result[w].halt && result[w].dest != '0;
			commit[w].wr_idx  = result[w].dest;
			commit[w].wr_data = result[w].value;

			writes[w].wr_en   = commit[w].wr_en;
			writes[w].wr_idx  = commit[w].wr_idx;
			writes[w].wr_data = commit[w].wr_data;

			// halts and illegals still count as completed
			completed_insts = completed_insts + TAKEN_W'(result[w].valid);
			any_illegal     = any_illegal | (result[w].valid & result[w].illegal);
			any_halt        = any_halt | (result[w].valid & result[w].halt);
		end

		if (any_illegal)
			error_status = ILLEGAL_INST;   // beats a halt in the same cycle
		else if (any_halt)
			error_status = HALTED_ON_WFI;
		else
			error_status = NO_ERROR;
	end

endmodule

`default_nettype wire

// File: source/superscalar_core.sv
`default_nettype none

module superscalar_core (
	input  logic                                clock,
	input  logic                                reset,
	input  superscalar_pkg::fetch_bundle_t      fetch_bundle,
	output logic [superscalar_pkg::TAKEN_W-1:0] taken,
	output superscalar_pkg::commit_t            commit [superscalar_pkg::WAYS],
	output logic [superscalar_pkg::TAKEN_W-1:0] completed_insts,
	output superscalar_pkg::error_status_t      error_status
);
	import superscalar_pkg::*;

	logic [REG_IDX_W-1:0] rd_idx  [2*WAYS];
	logic [XLEN-1:0]      rd_data [2*WAYS];
	issue_pkt_t           issue   [WAYS];
	result_pkt_t          result  [WAYS];
	reg_write_t           writes  [WAYS];

	////////////////////////////////////////////////////////////////////////////
	// issue, register read
	////////////////////////////////////////////////////////////////////////////

	bundle_issue bundle_issue_i (
		.clock        (clock),
		.reset        (reset),
		.fetch_bundle (fetch_bundle),
		.taken        (taken),
		.rd_idx       (rd_idx),
		.rd_data      (rd_data),
		.issue        (issue)
	);

	reg_file reg_file_i (
		.clock   (clock),
		.reset   (reset),
		.writes  (writes),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// execute ways and retire
	////////////////////////////////////////////////////////////////////////////

	for (genvar w = 0; w < WAYS; w++) begin : g_way
		alu_way alu_way_i (
			.clock  (clock),
			.reset  (reset),
			.issue  (issue[w]),
			.result (result[w])
		);
	end

	retire_unit retire_unit_i (
		.result          (result),
		.writes          (writes),
		.commit          (commit),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

endmodule

`default_nettype wire

// File: source/superscalar_pkg.sv
`default_nettype none

package superscalar_pkg;

	////////////////////////////////////////////////////////////////////////////
	// machine sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int WAYS      = 3;   // issue width
	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 32;
	localparam int TAKEN_W   = 2;   // holds 0..WAYS

	// decoded encodings
	localparam logic [6:0]  OPCODE_OP     = 7'b0110011;
	localparam logic [6:0]  OPCODE_OP_IMM = 7'b0010011;
	localparam logic [31:0] INST_WFI      = 32'h1050_0073;

	////////////////////////////////////////////////////////////////////////////
	// instruction word, read as R-type or I-type
	////////////////////////////////////////////////////////////////////////////

	typedef union packed {
		struct packed {
			logic [6:0]           funct7;
			logic [REG_IDX_W-1:0] rs2;
			logic [REG_IDX_W-1:0] rs1;
			logic [2:0]           funct3;
			logic [REG_IDX_W-1:0] rd;
			logic [6:0]           opcode;
		} r;
		struct packed {
			logic [11:0]          imm;
			logic [REG_IDX_W-1:0] rs1;
			logic [2:0]           funct3;
			logic [REG_IDX_W-1:0] rd;
			logic [6:0]           opcode;
		} i;
	} inst_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR
	} alu_op_t;

	typedef enum logic [1:0] {
		NO_ERROR,
		ILLEGAL_INST,
		HALTED_ON_WFI
	} error_status_t;

	////////////////////////////////////////////////////////////////////////////
	// stage packets
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		inst_t [WAYS-1:0] inst;
		logic  [WAYS-1:0] valid;
	} fetch_bundle_t;

	typedef struct packed {
		logic                 valid;
		alu_op_t              alu_op;
		logic [XLEN-1:0]      opa;
		logic [XLEN-1:0]      opb;
		logic [REG_IDX_W-1:0] dest;    // zero when nothing is written
		logic                 halt;
		logic                 illegal;
	} issue_pkt_t;

	typedef struct packed {
		logic                 valid;
		logic [REG_IDX_W-1:0] dest;
		logic [XLEN-1:0]      value;
		logic                 halt;
		logic                 illegal;
	} result_pkt_t;

	typedef struct packed {
		logic                 valid;
		logic                 wr_en;
		logic [REG_IDX_W-1:0] wr_idx;
		logic [XLEN-1:0]      wr_data;
	} commit_t;

	typedef struct packed {
		logic                 wr_en;
		logic [REG_IDX_W-1:0] wr_idx;
		logic [XLEN-1:0]      wr_data;
	} reg_write_t;

endpackage

`default_nettype wire

// File: tb.f
source/superscalar_pkg.sv
source/reg_file.sv
source/bundle_issue.sv
source/alu_way.sv
source/retire_unit.sv
source/superscalar_core.sv
verif/core_tb.sv

// File: verif/core_tb.sv
`default_nettype none

module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import superscalar_pkg::*;

	typedef enum logic [1:0] {
		K_WRITE,
		K_X0,
		K_ILLEGAL,
		K_HALT
	} kind_t;

	typedef struct packed {
		int      tag;   // cycle in which the commit is visible
		int      way;
		commit_t c;
		logic    illegal;
		logic    halt;
	} pending_t;

	logic               clock = 1'b0;
	logic               reset;
	fetch_bundle_t      fetch_bundle;
	logic [TAKEN_W-1:0] taken;
	commit_t            commit [WAYS];
	logic [TAKEN_W-1:0] completed_insts;
	error_status_t      error_status;

	logic [31:0]          table_inst [$];
	kind_t                table_kind [$];
	pending_t             pending [$];
	logic [XLEN-1:0]      model_regs [NUM_REGS];
	logic [REG_IDX_W-1:0] issue_dest [WAYS];   // mirror of the issue registers
	logic                 issue_busy [WAYS];
	logic [15:0]          lfsr = 16'd25833;
	int                   ptr;
	int                   offered;
	int                   cyc;
	int                   watch_cycles = 0;
	int                   commit_errs = 0;
	int                   count_errs = 0;
	int                   status_errs = 0;

	superscalar_core superscalar_core_i (
		.clock           (clock),
		.reset           (reset),
		.fetch_bundle    (fetch_bundle),
		.taken           (taken),
		.commit          (commit),
		.completed_insts (completed_insts),
		.error_status    (error_status)
	);

	always #4 clock = ~clock;

	// run limit scales with the table
	always @(negedge clock) begin
		watch_cycles = watch_cycles + 1;
		if (watch_cycles > 4 * table_inst.size() + 20) begin
			$display("Timeout: commits still outstanding after %0d cycles", watch_cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// encoders and table
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
			input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), OPCODE_OP};
	endfunction

	function automatic logic [31:0] i_word(input int imm, input int rs1, input int rd);
		return {12'(imm), 5'(rs1), 3'b000, 5'(rd), OPCODE_OP_IMM};   // addi
	endfunction

	task automatic push_entry(input logic [31:0] word, input kind_t kind);
		table_inst.push_back(word);
		table_kind.push_back(kind);
	endtask

	task automatic fill_table();
		// three independent ADDIs
		push_entry(i_word(5, 0, 1), K_WRITE);
		push_entry(i_word(-3, 0, 2), K_WRITE);
		push_entry(i_word(100, 0, 3), K_WRITE);
		// dependent ways inside one bundle
		push_entry(r_word(7'h00, 3'b000, 4, 1, 2), K_WRITE);   // add
		push_entry(r_word(7'h20, 3'b000, 5, 3, 1), K_WRITE);   // sub
		push_entry(r_word(7'h00, 3'b100, 6, 1, 3), K_WRITE);   // xor
		push_entry(r_word(7'h00, 3'b111, 7, 4, 5), K_WRITE);   // and
		push_entry(r_word(7'h00, 3'b110, 8, 7, 6), K_WRITE);   // or
		push_entry(i_word(-1, 8, 9), K_WRITE);
		push_entry(r_word(7'h20, 3'b000, 10, 9, 2), K_WRITE);
		push_entry(i_word(-40, 10, 10), K_WRITE);              // reads its own dest
		// x0 as dest and as source
		push_entry(i_word(7, 1, 0), K_X0);
		push_entry(r_word(7'h00, 3'b000, 11, 0, 1), K_WRITE);
		push_entry(r_word(7'h00, 3'b000, 0, 4, 5), K_X0);
		push_entry(r_word(7'h20, 3'b000, 12, 0, 11), K_WRITE);
		// illegal encodings and halts
		push_entry(32'h0000_2083, K_ILLEGAL);                  // lw x1
		push_entry(r_word(7'h00, 3'b000, 13, 1, 12), K_WRITE);
		push_entry(INST_WFI, K_HALT);
		push_entry(i_word(-2048, 13, 14), K_WRITE);
		push_entry(r_word(7'h01, 3'b000, 15, 1, 2), K_ILLEGAL); // mul
		push_entry(INST_WFI, K_HALT);
		push_entry({12'd5, 5'd1, 3'b010, 5'd1, OPCODE_OP_IMM}, K_ILLEGAL);   // slti
		push_entry(32'h0000_0073, K_ILLEGAL);                  // ecall
		push_entry(r_word(7'h00, 3'b100, 16, 14, 10), K_WRITE);
		push_entry(r_word(7'h20, 3'b000, 16, 16, 16), K_WRITE);
		push_entry(i_word(1, 16, 17), K_WRITE);
		push_entry(r_word(7'h00, 3'b000, 17, 17, 17), K_WRITE);
		// same dest twice, then a reader
		push_entry(i_word(11, 0, 18), K_WRITE);
		push_entry(i_word(22, 0, 18), K_WRITE);
		push_entry(i_word(0, 18, 19), K_WRITE);
		push_entry(r_word(7'h00, 3'b110, 20, 19, 2), K_WRITE);
		push_entry(r_word(7'h00, 3'b111, 21, 20, 9), K_WRITE);
		push_entry(i_word(-7, 21, 22), K_WRITE);
		push_entry(INST_WFI, K_HALT);
		push_entry(r_word(7'h00, 3'b000, 23, 22, 0), K_WRITE);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	function automatic logic [REG_IDX_W-1:0] dest_of(input int idx);
		logic [31:0] w;
		w = table_inst[idx];
		return (table_kind[idx] == K_WRITE) ? w[11:7] : '0;
	endfunction

	// true when entry idx reads the nonzero register r
	function automatic logic reads_reg(input int idx, input logic [REG_IDX_W-1:0] r);
		logic [31:0] w;
		w = table_inst[idx];
		if (r == '0 || table_kind[idx] == K_ILLEGAL || table_kind[idx] == K_HALT)
			return 1'b0;
		return (w[19:15] == r) || (w[6:0] == OPCODE_OP && w[24:20] == r);
	endfunction

	function automatic int expect_taken();
		int   n;
		logic stop;
		n = 0;
		stop = 1'b0;
		for (int w = 0; w < offered; w++) begin
			for (int j = 0; j < w; j++) begin
				if (reads_reg(ptr + w, dest_of(ptr + j)))
					stop = 1'b1;
			end
			for (int j = 0; j < WAYS; j++) begin
				if (issue_busy[j] && reads_reg(ptr + w, issue_dest[j]))
					stop = 1'b1;
			end
			if (!stop)
				n++;
		end
		return n;
	endfunction

	function automatic logic [XLEN-1:0] model_value(input logic [31:0] w);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] v;
		a = model_regs[w[19:15]];
		b = model_regs[w[24:20]];
		case ({w[31:25], w[14:12]})
			{7'h20, 3'b000}: v = a - b;
			{7'h00, 3'b111}: v = a & b;
			{7'h00, 3'b110}: v = a | b;
			{7'h00, 3'b100}: v = a ^ b;
			default:         v = a + b;
		endcase
		if (w[6:0] == OPCODE_OP_IMM)
			v = a + {{(XLEN-12){w[31]}}, w[31:20]};   // sign-extended imm
		return v;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic compare_commit(input int way, input commit_t got, input commit_t want);
		if (got.valid !== want.valid) begin
			$display("Error commit[%0d].valid cycle %0d: got %h expected %h",
				way, cyc, got.valid, want.valid);
			commit_errs++;
		end else if (want.valid && got.wr_en !== want.wr_en) begin
			$display("Error commit[%0d].wr_en cycle %0d: got %h expected %h",
				way, cyc, got.wr_en, want.wr_en);
			commit_errs++;
		end else if (want.wr_en && {got.wr_idx, got.wr_data} !== {want.wr_idx, want.wr_data}) begin
			$display("Error commit[%0d] idx/data cycle %0d: got %h/%h expected %h/%h",
				way, cyc, got.wr_idx, got.wr_data, want.wr_idx, want.wr_data);
			commit_errs++;
		end
	endtask

	task automatic compare_count(input string name, input logic [TAKEN_W-1:0] got,
			input logic [TAKEN_W-1:0] want);
		if (got !== want) begin
			$display("Error %s cycle %0d: got %h expected %h", name, cyc, got, want);
			count_errs++;
		end
	endtask

	task automatic compare_status(input error_status_t got, input error_status_t want);
		if (got !== want) begin
			$display("Error error_status cycle %0d: got %h expected %h", cyc, got, want);
			status_errs++;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// per-cycle steps
	////////////////////////////////////////////////////////////////////////////

	task automatic drive_bundle();
		fetch_bundle_t b;
		logic [1:0]    pick;
		b = '0;
		lfsr = lfsr_step(lfsr);
		pick[0] = lfsr[0];
		lfsr = lfsr_step(lfsr);
		pick[1] = lfsr[0];
		offered = (pick == 2'd0) ? 1 : (pick == 2'd1) ? 2 : 3;   // leans to full bundles
		if (offered > table_inst.size() - ptr)
			offered = table_inst.size() - ptr;
		for (int w = 0; w < offered; w++) begin
			b.inst[w]  = inst_t'(table_inst[ptr + w]);
			b.valid[w] = 1'b1;
		end
		fetch_bundle <= b;
	endtask

	task automatic check_commits();
		commit_t            want [WAYS];
		logic [TAKEN_W-1:0] n;
		logic               ill;
		logic               hlt;
		n = '0;
		ill = 1'b0;
		hlt = 1'b0;
		for (int w = 0; w < WAYS; w++)
			want[w] = '0;
		while (pending.size() != 0 && pending[0].tag == cyc) begin
			want[pending[0].way] = pending[0].c;
			n = n + 1'b1;
			ill = ill | pending[0].illegal;
			hlt = hlt | pending[0].halt;
			void'(pending.pop_front());
		end
		for (int w = 0; w < WAYS; w++)
			compare_commit(w, commit[w], want[w]);
		compare_count("completed_insts", completed_insts, n);
		compare_status(error_status, ill ? ILLEGAL_INST : (hlt ? HALTED_ON_WFI : NO_ERROR));
	endtask

	// in program order, so each value sees the ones before it
	task automatic accept_ways(input int n);
		pending_t    p;
		logic [31:0] w;
		for (int i = 0; i < WAYS; i++) begin
			issue_busy[i] = (i < n);
			issue_dest[i] = '0;
		end
		for (int i = 0; i < n; i++) begin
			w = table_inst[ptr + i];
			p = '0;
			p.tag = cyc + 2;
			p.way = i;
			p.c.valid = 1'b1;
			p.c.wr_en = (table_kind[ptr + i] == K_WRITE);
			p.c.wr_idx = w[11:7];
			p.c.wr_data = model_value(w);
			p.illegal = (table_kind[ptr + i] == K_ILLEGAL);
			p.halt = (table_kind[ptr + i] == K_HALT);
			if (p.c.wr_en)
				model_regs[w[11:7]] = p.c.wr_data;
			issue_dest[i] = dest_of(ptr + i);
			pending.push_back(p);
		end
		ptr = ptr + n;
	endtask

	initial begin
		int n;
		reset <= 1'b0;
		fetch_bundle <= '0;
		fill_table();
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
		for (int w = 0; w < WAYS; w++) begin
			issue_busy[w] = 1'b0;
			issue_dest[w] = '0;
		end
		ptr = 0;
		cyc = 0;

		while (ptr < table_inst.size() || pending.size() != 0) begin
			@(posedge clock);
			cyc++;
			if (cyc == 2)
				reset <= 1'b1;   // low through the first two edges
			drive_bundle();
			@(negedge clock);
			check_commits();
			if (!reset) begin
				compare_count("taken", taken, '0);
			end else begin
				compare_count("taken", taken, TAKEN_W'(expect_taken()));
				n = int'(taken);
				if (n > offered)
					n = offered;
				accept_ways(n);
			end
		end

		$display("errors: commit %0d, count %0d, status %0d",
			commit_errs, count_errs, status_errs);
		if (commit_errs + count_errs + status_errs == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
